// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP ?= lsu_tb
FILELIST ?= filelist.f
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qx "Finished with errors" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
src/lsu_pkg.sv
src/lsu_req_format.sv
src/lsu_wb_master.sv
src/lsu_load_format.sv
src/lsu_commit_queue.sv
src/lsu_top.sv
testbench/lsu_wb_sva.sv
testbench/lsu_tb.sv

// ==== src/lsu_commit_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_commit_queue (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         push,
    input  wire lsu_pkg::lsu_commit_t   push_data,
    output logic                        full,
    output lsu_pkg::lsu_commit_t        commit,
    output logic                        commit_valid,
    input  wire                         commit_ready
);
    import lsu_pkg::*;

    lsu_commit_t                entries [queue_depth];
    logic [queue_ptr_bits-1:0]  wr_ptr;
    logic [queue_ptr_bits-1:0]  rd_ptr;
    logic [queue_ptr_bits:0]    count;
    logic                       pop;

    assign commit_valid = (count != '0);
    assign full = (count == (queue_ptr_bits + 1)'(queue_depth));
    assign pop = commit_valid && commit_ready;
    assign commit = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // entry written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu_load_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_load_format (
    input  wire [lsu_pkg::xlen-1:0]         rsp_data,
    input  wire [lsu_pkg::align_bits-1:0]   rsp_align,
    input  wire lsu_pkg::lsu_op_u           rsp_op,
    input  wire [lsu_pkg::rd_width-1:0]     rsp_rd,
    input  wire [lsu_pkg::tag_width-1:0]    rsp_tag,
    output lsu_pkg::lsu_commit_t            done_rsp
);
    import lsu_pkg::*;

    logic [15:0]  half_sel;
    logic [7:0]   byte_sel;
    logic         is_unsigned;

    // halfword by upper offset bit, byte by lower
    assign half_sel = rsp_align[1] ? rsp_data[31:16] : rsp_data[15:0];
    assign byte_sel = rsp_align[0] ? half_sel[15:8] : half_sel[7:0];
    assign is_unsigned = rsp_op.load_fmt.is_unsigned;

    always_comb begin
        done_rsp.tag = rsp_tag;
        done_rsp.rd = rsp_rd;
        done_rsp.wb = 1'b1;
        case (rsp_op.load_fmt.size)
            size_byte: begin
                if (is_unsigned) begin
                    done_rsp.data = xlen'(unsigned'(byte_sel));
                end else begin
                    done_rsp.data = xlen'(signed'(byte_sel));
                end
            end
            size_half: begin
                if (is_unsigned) begin
                    done_rsp.data = xlen'(unsigned'(half_sel));
                end else begin
                    done_rsp.data = xlen'(signed'(half_sel));
                end
            end
            default: begin
                done_rsp.data = rsp_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int xlen = 32;
    localparam int byte_count = xlen / 8;
    localparam int align_bits = $clog2(byte_count);
    localparam int word_addr_width = xlen - align_bits;
    localparam int tag_width = 4;
    localparam int rd_width = 5;

    // commit FIFO sizing
    localparam int queue_depth = 2;
    localparam int queue_ptr_bits = $clog2(queue_depth);

    typedef enum logic [1:0] {
        kind_load  = 2'd0,
        kind_store = 2'd1,
        kind_fence = 2'd2
    } lsu_kind_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_e;

    typedef struct packed {
        logic      is_unsigned;
        lsu_size_e size;
    } lsu_load_fmt_t;

    typedef struct packed {
        logic      rsvd;
        lsu_size_e size;
    } lsu_store_fmt_t;

    // view selected by lsu_kind_e
    typedef union packed {
        lsu_load_fmt_t  load_fmt;
        lsu_store_fmt_t store_size;
    } lsu_op_u;

    typedef struct packed {
        lsu_kind_e             kind;
        lsu_op_u               op;
        logic [xlen-1:0]       base;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       wdata;
        logic [rd_width-1:0]   rd;
        logic [tag_width-1:0]  tag;
    } lsu_req_t;

    typedef struct packed {
        logic [tag_width-1:0]  tag;
        logic [rd_width-1:0]   rd;
        logic                  wb;
        logic [xlen-1:0]       data;
    } lsu_commit_t;

    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [word_addr_width-1:0]  adr;
        logic [byte_count-1:0]       sel;
        logic [xlen-1:0]             dat;
    } wb_req_t;

    typedef struct packed {
        logic                        we;
        logic [word_addr_width-1:0]  adr;
        logic [byte_count-1:0]       sel;
        logic [xlen-1:0]             dat;
        logic [align_bits-1:0]       align;
        lsu_op_u                     op;
        logic [rd_width-1:0]         rd;
        logic [tag_width-1:0]        tag;
        logic                        is_fence;
    } lsu_access_t;

endpackage

`default_nettype wire

// ==== src/lsu_req_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_req_format (
    input  wire lsu_pkg::lsu_req_t     req,
    output lsu_pkg::lsu_access_t       access
);
    import lsu_pkg::*;

    logic [xlen-1:0]        addr;
    logic [align_bits-1:0]  align;
    logic                   is_store;
    logic [byte_count-1:0]  store_sel;

    assign addr = req.base + req.imm;
    assign align = addr[align_bits-1:0];
    assign is_store = (req.kind == kind_store);

    // byte lanes written by a store
    always_comb begin
        store_sel = '0;
        case (req.op.store_size.size)
            size_byte: begin
                store_sel[align] = 1'b1;
            end
            size_half: begin
                store_sel[{align[1], 1'b0}] = 1'b1;
                store_sel[{align[1], 1'b1}] = 1'b1;
            end
            size_word: begin
                store_sel = '1;
            end
            default: begin
                store_sel = '1;
            end
        endcase
    end

    always_comb begin
        access.we = is_store;
        access.adr = addr[xlen-1:align_bits];
        // loads always read the full word
        access.sel = is_store ? store_sel : '1;
        // move store data into its lane
        access.dat = req.wdata << {align, 3'b000};
        access.align = align;
        access.op = req.op;
        access.rd = req.rd;
        access.tag = req.tag;
        access.is_fence = (req.kind == kind_fence);
    end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire lsu_pkg::lsu_req_t      req,
    input  wire                         req_valid,
    output logic                        req_ready,
    output lsu_pkg::lsu_commit_t        commit,
    output logic                        commit_valid,
    input  wire                         commit_ready,
    output lsu_pkg::wb_req_t            wb,
    input  wire [lsu_pkg::xlen-1:0]     wb_dat_r,
    input  wire                         wb_ack
);
    import lsu_pkg::*;

    lsu_access_t             access;
    logic [xlen-1:0]         rsp_data;
    logic [align_bits-1:0]   rsp_align;
    lsu_op_u                 rsp_op;
    logic [rd_width-1:0]     rsp_rd;
    logic [tag_width-1:0]    rsp_tag;
    lsu_commit_t             done_rsp;
    logic                    push;
    lsu_commit_t             push_data;
    logic                    queue_full;

    lsu_req_format i_req_format (
        .req    (req),
        .access (access)
    );

    lsu_wb_master i_wb_master (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .access     (access),
        .wb         (wb),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .rsp_data   (rsp_data),
        .rsp_align  (rsp_align),
        .rsp_op     (rsp_op),
        .rsp_rd     (rsp_rd),
        .rsp_tag    (rsp_tag),
        .done_rsp   (done_rsp),
        .push       (push),
        .push_data  (push_data),
        .queue_full (queue_full)
    );

    lsu_load_format i_load_format (
        .rsp_data  (rsp_data),
        .rsp_align (rsp_align),
        .rsp_op    (rsp_op),
        .rsp_rd    (rsp_rd),
        .rsp_tag   (rsp_tag),
        .done_rsp  (done_rsp)
    );

    lsu_commit_queue i_commit_queue (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .push_data    (push_data),
        .full         (queue_full),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

// ==== src/lsu_wb_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_master (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                req_valid,
    output logic                               req_ready,
    input  wire lsu_pkg::lsu_access_t          access,
    output lsu_pkg::wb_req_t                   wb,
    input  wire [lsu_pkg::xlen-1:0]            wb_dat_r,
    input  wire                                wb_ack,
    output logic [lsu_pkg::xlen-1:0]           rsp_data,
    output logic [lsu_pkg::align_bits-1:0]     rsp_align,
    output lsu_pkg::lsu_op_u                   rsp_op,
    output logic [lsu_pkg::rd_width-1:0]       rsp_rd,
    output logic [lsu_pkg::tag_width-1:0]      rsp_tag,
    input  wire lsu_pkg::lsu_commit_t          done_rsp,
    output logic                               push,
    output lsu_pkg::lsu_commit_t               push_data,
    input  wire                                queue_full
);
    import lsu_pkg::*;

    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } state_e;

    state_e       state;
    lsu_access_t  cur;
    logic         accept;
    logic         fence_done;
    logic         bus_done;

    // one access outstanding, and only with room in the queue
    assign req_ready = (state == st_idle) && !queue_full;
    assign accept = req_valid && req_ready;
    assign fence_done = accept && access.is_fence;
    assign bus_done = (state == st_busy) && wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && !access.is_fence) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (wb_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // held stable until ack
    always_ff @(posedge clk) begin
        if (accept && !access.is_fence) begin
            cur <= access;
        end
    end

    always_comb begin
        wb.cyc = (state == st_busy);
        wb.stb = (state == st_busy);
        wb.we = cur.we;
        wb.adr = cur.adr;
        wb.sel = cur.sel;
        wb.dat = cur.dat;
    end

    // to load formatting
    assign rsp_data = wb_dat_r;
    assign rsp_align = cur.align;
    assign rsp_op = cur.op;
    assign rsp_rd = cur.rd;
    assign rsp_tag = cur.tag;

    assign push = fence_done || bus_done;

    always_comb begin
        push_data = '0;
        if (fence_done) begin
            push_data.tag = access.tag;
            push_data.rd = access.rd;
        end else if (cur.we) begin
            push_data.tag = cur.tag;
            push_data.rd = cur.rd;
        end else begin
            push_data = done_rsp;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int mem_words = 256;
    localparam int wait_limit = 2000;

    logic             clk;
    logic             reset;
    lsu_req_t         req;
    logic             req_valid;
    logic             req_ready;
    lsu_commit_t      commit;
    logic             commit_valid;
    logic             commit_ready;
    wb_req_t          wb;
    logic [xlen-1:0]  wb_dat_r;
    logic             wb_ack;

    logic [xlen-1:0]       mem [mem_words];
    logic [xlen-1:0]       shadow [mem_words];
    lsu_commit_t           exp_commits [$];
    // expected bus accesses, cyc and stb unused
    wb_req_t               exp_bus [$];
    logic [31:0]           stim_rng;
    logic [31:0]           mem_rng;
    logic [31:0]           ready_rng;
    logic                  stall;
    logic                  random_ready;
    logic [tag_width-1:0]  next_tag;
    int                    errors;
    int                    checks;
    int                    tests_run;
    int                    failed_tests;
    int                    test_errors_start;

    lsu_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .wb           (wb),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [xlen-1:0] fill_word(input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {a, ~a, a ^ 8'h5a, a + 8'h3c};
    endfunction

    // expected commit and bus access, in issue order
    function automatic lsu_commit_t predict(input lsu_req_t r);
        lsu_commit_t      c;
        wb_req_t          b;
        logic [xlen-1:0]  addr;
        logic [7:0]       idx;
        logic [1:0]       off;
        logic [xlen-1:0]  shifted;
        c = '0;
        b = '0;
        addr = r.base + r.imm;
        idx = addr[9:2];
        off = addr[1:0];
        c.tag = r.tag;
        c.rd = r.rd;
        b.adr = addr[xlen-1:2];
        if (r.kind == kind_store) begin
            b.we = 1'b1;
            b.dat = r.wdata << (8 * off);
            case (r.op.store_size.size)
                size_byte: b.sel = 4'b0001 << off;
                size_half: b.sel = 4'b0011 << off;
                default: b.sel = 4'b1111;
            endcase
            for (int i = 0; i < byte_count; i++) begin
                if (b.sel[i]) begin
                    shadow[idx][8*i +: 8] = b.dat[8*i +: 8];
                end
            end
            exp_bus.push_back(b);
        end else if (r.kind == kind_load) begin
            b.sel = 4'b1111;
            shifted = shadow[idx] >> (8 * off);
            c.wb = 1'b1;
            case (r.op.load_fmt.size)
                size_byte: begin
                    c.data = r.op.load_fmt.is_unsigned ? {24'b0, shifted[7:0]}
                                                       : {{24{shifted[7]}}, shifted[7:0]};
                end
                size_half: begin
                    c.data = r.op.load_fmt.is_unsigned ? {16'b0, shifted[15:0]}
                                                       : {{16{shifted[15]}}, shifted[15:0]};
                end
                default: c.data = shadow[idx];
            endcase
            exp_bus.push_back(b);
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Finished with errors");
        $finish;
    endtask

    // memory side of one bus access
    task automatic serve_access();
        wb_req_t          e;
        logic [xlen-1:0]  mask;
        logic [7:0]       idx;
        idx = wb.adr[7:0];
        checks++;
        assert (exp_bus.size() != 0) else begin
            $display("bus cycle seen with no access expected");
            errors++;
        end
        if (exp_bus.size() != 0) begin
            e = exp_bus.pop_front();
            mask = {{8{e.sel[3]}}, {8{e.sel[2]}}, {8{e.sel[1]}}, {8{e.sel[0]}}};
            check_value("wb.adr", 32'(wb.adr), 32'(e.adr));
            check_value("wb.we", 32'(wb.we), 32'(e.we));
            check_value("wb.sel", 32'(wb.sel), 32'(e.sel));
            if (e.we) begin
                check_value("wb.dat", wb.dat & mask, e.dat & mask);
            end
        end
        if (wb.we) begin
            for (int i = 0; i < byte_count; i++) begin
                if (wb.sel[i]) begin
                    mem[idx][8*i +: 8] = wb.dat[8*i +: 8];
                end
            end
        end else begin
            wb_dat_r = mem[idx];
        end
    endtask

    initial begin : memory_model
        int    delay;
        logic  busy;
        wb_dat_r = '0;
        wb_ack = 1'b0;
        busy = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            #10;
            if (wb_ack) begin
                wb_ack = 1'b0;
                busy = 1'b0;
            end else if (wb.cyc && wb.stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    mem_rng = xorshift(mem_rng);
                    delay = int'(mem_rng[1:0]);
                end
                if (delay == 0) begin
                    serve_access();
                    wb_ack = 1'b1;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : compare_commits
        lsu_commit_t e;
        commit_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (stall) begin
                commit_ready = 1'b0;
            end else if (random_ready) begin
                ready_rng = xorshift(ready_rng);
                commit_ready = ready_rng[0];
            end else begin
                commit_ready = 1'b1;
            end
            @(negedge clk);
            if (!reset && commit_valid && commit_ready) begin
                checks++;
                assert (exp_commits.size() != 0) else begin
                    $display("commit arrived with none expected");
                    errors++;
                end
                if (exp_commits.size() != 0) begin
                    e = exp_commits.pop_front();
                    check_value("commit.tag", 32'(commit.tag), 32'(e.tag));
                    check_value("commit.rd", 32'(commit.rd), 32'(e.rd));
                    check_value("commit.wb", 32'(commit.wb), 32'(e.wb));
                    if (e.wb) begin
                        check_value("commit.data", commit.data, e.data);
                    end
                end
            end
        end
    end

    // called at 10 ns after a rising edge
    task automatic send(input lsu_kind_e kind, input lsu_size_e size, input logic uns,
                        input logic [xlen-1:0] base, input logic [xlen-1:0] imm,
                        input logic [xlen-1:0] wdata);
        lsu_req_t  r;
        int        waited;
        r = '0;
        r.kind = kind;
        if (kind == kind_store) begin
            r.op.store_size.size = size;
        end else begin
            r.op.load_fmt.size = size;
            r.op.load_fmt.is_unsigned = uns;
        end
        r.base = base;
        r.imm = imm;
        r.wdata = wdata;
        r.rd = {1'b1, next_tag};
        r.tag = next_tag;
        exp_commits.push_back(predict(r));
        req = r;
        req_valid = 1'b1;
        waited = 0;
        while (!req_ready) begin
            @(posedge clk);
            #10;
            waited++;
            if (waited > wait_limit) abort_run("request was never accepted");
        end
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        next_tag++;
    endtask

    task automatic set_ready(input logic hold, input logic rand_mode);
        @(negedge clk);
        stall = hold;
        random_ready = rand_mode;
        @(posedge clk);
        #10;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (exp_commits.size() != 0) begin
            @(posedge clk);
            #10;
            waited++;
            if (waited > wait_limit) abort_run("expected commits never arrived");
        end
        tests_run++;
        if (errors == test_errors_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors_start);
            failed_tests++;
        end
        test_errors_start = errors;
    endtask

    initial begin : stimulus
        lsu_kind_e        kind;
        lsu_size_e        sz;
        logic [31:0]      pick;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  imm;
        reset = 1'b1;
        req = '0;
        req_valid = 1'b0;
        stall = 1'b0;
        random_ready = 1'b0;
        next_tag = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        failed_tests = 0;
        test_errors_start = 0;
        stim_rng = 32'hbe19;
        mem_rng = xorshift(32'hbe19);
        ready_rng = xorshift(mem_rng);
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        send(kind_store, size_word, 1'b0, 32'h100, 32'hffff_ffe0, 32'hcafe_f00d);
        send(kind_load, size_word, 1'b0, 32'h0e0, 32'h0, 32'h0);
        finish_test("word store then load");

        for (int off = 0; off < 4; off++) begin
            send(kind_store, size_byte, 1'b0, 32'h80, 32'(off), 32'h1234_5600 + 32'(off));
        end
        send(kind_store, size_half, 1'b0, 32'h84, 32'h0, 32'h0bad_a5c3);
        send(kind_store, size_half, 1'b0, 32'h84, 32'h2, 32'h0bad_7e11);
        send(kind_load, size_word, 1'b0, 32'h80, 32'h0, 32'h0);
        send(kind_load, size_word, 1'b0, 32'h80, 32'h4, 32'h0);
        finish_test("byte and half stores");

        // byte values 01 7f ff 80 give both signs
        send(kind_store, size_word, 1'b0, 32'h90, 32'h0, 32'h80ff_7f01);
        for (int off = 0; off < 4; off++) begin
            send(kind_load, size_byte, 1'b0, 32'h90, 32'(off), 32'h0);
            send(kind_load, size_byte, 1'b1, 32'h90, 32'(off), 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            send(kind_load, size_half, 1'b0, 32'h90, 32'(off), 32'h0);
            send(kind_load, size_half, 1'b1, 32'h90, 32'(off), 32'h0);
        end
        finish_test("signed and unsigned loads");

        for (int n = 0; n < 3; n++) begin
            send(kind_store, size_word, 1'b0, 32'h200, 32'(4 * n), 32'h5a5a_0000 + 32'(n));
        end
        send(kind_fence, size_word, 1'b0, 32'h0, 32'h0, 32'h0);
        finish_test("fence after stores");
        checks++;
        assert (exp_bus.size() == 0) else begin
            $display("bus accesses still expected after the fence");
            errors++;
        end

        set_ready(1'b1, 1'b0);
        fork
            begin
                for (int n = 0; n < 6; n++) begin
                    send(n[0] ? kind_load : kind_store, size_word, 1'b0, 32'h300,
                         32'(4 * (n / 2)), 32'h7700_0000 + 32'(n));
                end
            end
            begin
                repeat (20) @(negedge clk);
                checks++;
                assert (!req_ready) else begin
                    $display("req_ready stayed high while commits were held back");
                    errors++;
                end
                stall = 1'b0;
            end
        join
        finish_test("back-pressure");

        set_ready(1'b0, 1'b1);
        for (int n = 0; n < 200; n++) begin
            stim_rng = xorshift(stim_rng);
            pick = stim_rng;
            if (pick[2:0] == 3'd0) begin
                kind = kind_fence;
            end else if (pick[3]) begin
                kind = kind_store;
            end else begin
                kind = kind_load;
            end
            case (pick[5:4])
                2'd0: sz = size_byte;
                2'd1: sz = size_half;
                default: sz = size_word;
            endcase
            addr = {22'b0, pick[15:6]};
            if (sz == size_half) begin
                addr[0] = 1'b0;
            end else if (sz == size_word) begin
                addr[1:0] = 2'b00;
            end
            stim_rng = xorshift(stim_rng);
            imm = stim_rng;
            stim_rng = xorshift(stim_rng);
            send(kind, sz, pick[16], addr - imm, imm, stim_rng);
        end
        finish_test("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/lsu_wb_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_sva (
    input wire                     clk,
    input wire                     reset,
    input wire lsu_pkg::wb_req_t   wb,
    input wire                     wb_ack,
    input wire                     push,
    input wire                     queue_full
);

    // cyc and stb stay up until ack
    held_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb.stb && !wb_ack) |=> (wb.cyc && wb.stb))
        else $error("cyc or stb dropped before ack");

    drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        (wb.stb && wb_ack) |=> !(wb.cyc || wb.stb))
        else $error("cyc or stb still high after ack");

    // request held until ack
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (wb.stb && !wb_ack) |=> $stable({wb.we, wb.adr, wb.sel, wb.dat}))
        else $error("bus request changed before ack");

    sel_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb.stb |-> (wb.sel != '0))
        else $error("stb high with empty sel");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !queue_full)
        else $error("commit pushed into a full queue");

endmodule

bind lsu_wb_master lsu_wb_sva i_wb_sva (
    .clk        (clk),
    .reset      (reset),
    .wb         (wb),
    .wb_ack     (wb_ack),
    .push       (push),
    .queue_full (queue_full)
);

`default_nettype wire
